/* hdl/board_pkg.sv */
`default_nettype none

package board_pkg;

    // Keys, LEDs and dots come in groups of four on this board.
    // Inside the design a key bit of 1 means the key is pressed.
    typedef logic [3:0] key_t;

    // The display has four digits, and each digit shows one hex nibble.
    localparam int num_digits = 4;
    localparam int nibble_width = 4;

    // One hex value, as shown on a single digit.
    typedef logic [nibble_width-1:0] hex_t;

    // Nibble i of the word is shown on digit i, so digit 0 holds the low nibble.
    typedef logic [num_digits*nibble_width-1:0] display_word_t;

    // Segments abcdefg sit on bits 7 to 1 and the dot on bit 0.
    // All of them are active low, as the display is common anode.
    typedef logic [7:0] segments_t;

endpackage

`default_nettype wire

/* hdl/detect_pkg.sv */
`default_nettype none

package detect_pkg;

    // The pattern to find, with the oldest bit at index 2.
    // The detectors allow overlap, so 10101 holds two matches.
    localparam logic [2:0] pattern = 3'b101;

    // The Moore machine reports a match by sitting in the accept state.
    typedef enum logic [1:0] {
        moore_idle,
        moore_seen_1,
        moore_seen_10,
        moore_accept
    } moore_state_e;

    // The Mealy machine needs no accept state.
    // It reports on the transition out of seen_10 instead.
    typedef enum logic [1:0] {
        mealy_idle,
        mealy_seen_1,
        mealy_seen_10
    } mealy_state_e;

endpackage

`default_nettype wire

/* hdl/tick_gen.sv */
`default_nettype none
`timescale 1ns/100ps

module tick_gen
# (
    parameter int width = 8
)
(
    input  logic clk,
    input  logic i_reset,
    output logic o_tick
);

    // Free-running counter.
    // One full turn takes 2^width clock cycles.
    logic [width-1:0] count;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // The strobe is high in the one cycle where the counter holds all ones.
    // The next edge wraps the counter, so the strobe never lasts longer.
    assign o_tick = &count;

endmodule

`default_nettype wire

/* hdl/key_debounce.sv */
`default_nettype none
`timescale 1ns/100ps

module key_debounce
# (
    parameter int depth = 8
)
(
    input  logic            clk,
    input  logic            i_reset,
    input  board_pkg::key_t i_key,
    output board_pkg::key_t o_key
);

    import board_pkg::*;

    // Two synchronizer stages, already inverted so that 1 means pressed.
    key_t sync_1;
    key_t sync_2;

    // Debounced state of every key.
    key_t key_state;

    // One stability counter per key.
    // The extra top bit marks saturation after 2^depth stable cycles.
    logic [depth:0] count [$bits(key_t)];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1 <= ~i_key;
            sync_2 <= sync_1;
        end
    end

    // A counter runs only while its key disagrees with the debounced state.
    // Any return to agreement clears it, so short glitches never get through.
    // Latency from pin to output is two sync edges, 2^depth count edges and the flip.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            key_state <= '0;
            for (int i = 0; i < $bits(key_t); i++) begin
                count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < $bits(key_t); i++) begin
                if (sync_2[i] == key_state[i]) begin
                    count[i] <= '0;
                end else if (count[i][depth]) begin
                    // Stable long enough, so take the new level.
                    key_state[i] <= sync_2[i];
                    count[i]     <= '0;
                end else begin
                    count[i] <= count[i] + 1'b1;
                end
            end
        end
    end

    assign o_key = key_state;

endmodule

`default_nettype wire

/* hdl/pattern_detect.sv */
`default_nettype none
`timescale 1ns/100ps

module pattern_detect (
    input  logic            clk,
    input  logic            i_reset,
    input  logic            i_tick,
    input  logic            i_data,
    output board_pkg::key_t o_shift_bits,
    output logic            o_moore_hit,
    output logic            o_mealy_hit
);

    import board_pkg::*;
    import detect_pkg::*;

    // Shift register, newest bit at index 0.
    key_t shift_bits;

    // Bit seen by both detectors on the coming tick.
    logic bit_in;

    moore_state_e moore_state;
    moore_state_e moore_next;
    mealy_state_e mealy_state;
    mealy_state_e mealy_next;

    // The detectors read the bit that entered on the previous tick.
    // So they trail the shift register by one tick.
    assign bit_in = shift_bits[0];

    // Moore next state.
    // After accept, the last 1 can start a new match and a 0 extends one.
    always_comb begin
        moore_next = moore_state;
        case (moore_state)
            moore_idle: begin
                if (bit_in == pattern[2]) moore_next = moore_seen_1;
            end
            moore_seen_1: begin
                if (bit_in == pattern[1]) moore_next = moore_seen_10;
            end
            moore_seen_10: begin
                if (bit_in == pattern[0]) moore_next = moore_accept;
                else                      moore_next = moore_idle;
            end
            moore_accept: begin
                if (bit_in == pattern[1]) moore_next = moore_seen_10;
                else                      moore_next = moore_seen_1;
            end
            default: moore_next = moore_idle;
        endcase
    end

    // Mealy next state.
    // A completing 1 leaves the machine in seen_1, which keeps overlap.
    always_comb begin
        mealy_next = mealy_state;
        case (mealy_state)
            mealy_idle: begin
                if (bit_in == pattern[2]) mealy_next = mealy_seen_1;
            end
            mealy_seen_1: begin
                if (bit_in == pattern[1]) mealy_next = mealy_seen_10;
            end
            mealy_seen_10: begin
                if (bit_in == pattern[0]) mealy_next = mealy_seen_1;
                else                      mealy_next = mealy_idle;
            end
            default: mealy_next = mealy_idle;
        endcase
    end

    // Everything here moves only on the shift tick.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            shift_bits  <= '0;
            moore_state <= moore_idle;
            mealy_state <= mealy_idle;
        end else if (i_tick) begin
            shift_bits  <= {shift_bits[$bits(key_t)-2:0], i_data};
            moore_state <= moore_next;
            mealy_state <= mealy_next;
        end
    end

    assign o_shift_bits = shift_bits;

    // Moore output depends on the state alone and holds for a whole tick period.
    assign o_moore_hit = (moore_state == moore_accept);

    // Mealy output also looks at the input, so it rises a tick earlier.
    assign o_mealy_hit = (mealy_state == mealy_seen_10) && (bit_in == pattern[0]);

endmodule

`default_nettype wire

/* hdl/event_tally.sv */
`default_nettype none
`timescale 1ns/100ps

module event_tally (
    input  logic                     clk,
    input  logic                     i_reset,
    input  logic                     i_tick,
    input  logic                     i_moore_hit,
    input  logic                     i_mealy_hit,
    output board_pkg::display_word_t o_word
);

    import board_pkg::*;

    // The shift count fills every digit left over by the two hit counts.
    localparam int shift_width = (num_digits - 2) * nibble_width;

    logic [shift_width-1:0] shift_count;
    hex_t                   moore_count;
    hex_t                   mealy_count;

    // All three counters step on the tick edge and wrap silently.
    // A hit is counted only when it is high at that edge.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            shift_count <= '0;
            moore_count <= '0;
            mealy_count <= '0;
        end else if (i_tick) begin
            shift_count <= shift_count + 1'b1;
            if (i_moore_hit) begin
                moore_count <= moore_count + 1'b1;
            end
            if (i_mealy_hit) begin
                mealy_count <= mealy_count + 1'b1;
            end
        end
    end

    // Shift count on the two left digits, then Moore, then Mealy on digit 0.
    assign o_word = {shift_count, moore_count, mealy_count};

endmodule

`default_nettype wire

/* hdl/seven_segment.sv */
`default_nettype none
`timescale 1ns/100ps

module seven_segment (
    input  logic                            clk,
    input  logic                            i_reset,
    input  logic                            i_scan,
    input  board_pkg::display_word_t        i_word,
    input  board_pkg::key_t                 i_dots,
    output board_pkg::segments_t            o_segments,
    output logic [board_pkg::num_digits-1:0] o_digit
);

    import board_pkg::*;

    localparam int index_width = $clog2(num_digits);

    // Digit being driven; it wraps on its own since num_digits is a power of two.
    logic [index_width-1:0] index;

    // One-hot form of the index, active high.
    logic [num_digits-1:0] one_hot;

    hex_t       nibble;
    logic [6:0] abcdefg;

    // Hex to segment decoder.
    // The table is written active high for readability and inverted on return.
    function automatic logic [6:0] hex_to_abcdefg(input hex_t value);
        logic [6:0] lit;
        case (value)
            4'h0: lit = 7'b1111110;
            4'h1: lit = 7'b0110000;
            4'h2: lit = 7'b1101101;
            4'h3: lit = 7'b1111001;
            4'h4: lit = 7'b0110011;
            4'h5: lit = 7'b1011011;
            4'h6: lit = 7'b1011111;
            4'h7: lit = 7'b1110000;
            4'h8: lit = 7'b1111111;
            4'h9: lit = 7'b1111011;
            4'ha: lit = 7'b1110111;
            4'hb: lit = 7'b0011111;
            4'hc: lit = 7'b1001110;
            4'hd: lit = 7'b0111101;
            4'he: lit = 7'b1001111;
            4'hf: lit = 7'b1000111;
        endcase
        return ~lit;
    endfunction

    always_ff @(posedge clk) begin
        if (i_reset) begin
            index <= '0;
        end else if (i_scan) begin
            index <= index + 1'b1;
        end
    end

    assign one_hot = {{(num_digits - 1){1'b0}}, 1'b1} << index;
    assign nibble  = i_word[index*nibble_width +: nibble_width];
    assign abcdefg = hex_to_abcdefg(nibble);

    // Anode, segments and dot are registered together, one cycle behind the index.
    // Reset blanks the segments and already selects digit 0.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_digit    <= ~{{(num_digits - 1){1'b0}}, 1'b1};
            o_segments <= '1;
        end else begin
            o_digit    <= ~one_hot;
            o_segments <= {abcdefg, ~i_dots[index]};
        end
    end

endmodule

`default_nettype wire

/* hdl/pattern_top.sv */
`default_nettype none
`timescale 1ns/100ps

module pattern_top
# (
    parameter int debounce_depth   = 8,
    parameter int shift_tick_width = 23,
    parameter int scan_tick_width  = 10
)
(
    input  logic                 clk,
    input  logic                 i_reset,

    input  board_pkg::key_t      i_key_sw,
    output board_pkg::key_t      o_led,

    output board_pkg::segments_t o_abcdefgh,
    output logic [3:0]           o_digit
);

    import board_pkg::*;

    // Debounced keys, active high.
    key_t key_db;

    logic shift_tick;
    logic scan_tick;

    key_t          shift_bits;
    logic          moore_hit;
    logic          mealy_hit;
    display_word_t display_word;

    key_debounce # (.depth (debounce_depth)) u_key_debounce
    (
        .clk     ( clk      ),
        .i_reset ( i_reset  ),
        .i_key   ( i_key_sw ),
        .o_key   ( key_db   )
    );

    // Slow tick that clocks key 1 into the shift register.
    tick_gen # (.width (shift_tick_width)) u_shift_tick
    (
        .clk     ( clk        ),
        .i_reset ( i_reset    ),
        .o_tick  ( shift_tick )
    );

    pattern_detect u_pattern_detect
    (
        .clk          ( clk        ),
        .i_reset      ( i_reset    ),
        .i_tick       ( shift_tick ),
        .i_data       ( key_db[1]  ),
        .o_shift_bits ( shift_bits ),
        .o_moore_hit  ( moore_hit  ),
        .o_mealy_hit  ( mealy_hit  )
    );

    // LEDs are active low, so a 1 in the register lights its LED.
    assign o_led = ~shift_bits;

    event_tally u_event_tally
    (
        .clk         ( clk          ),
        .i_reset     ( i_reset      ),
        .i_tick      ( shift_tick   ),
        .i_moore_hit ( moore_hit    ),
        .i_mealy_hit ( mealy_hit    ),
        .o_word      ( display_word )
    );

    // Faster tick that steps the display from digit to digit.
    tick_gen # (.width (scan_tick_width)) u_scan_tick
    (
        .clk     ( clk       ),
        .i_reset ( i_reset   ),
        .o_tick  ( scan_tick )
    );

    // The dots mirror the debounced keys, key i on digit i.
    seven_segment u_seven_segment
    (
        .clk        ( clk          ),
        .i_reset    ( i_reset      ),
        .i_scan     ( scan_tick    ),
        .i_word     ( display_word ),
        .i_dots     ( key_db       ),
        .o_segments ( o_abcdefgh   ),
        .o_digit    ( o_digit      )
    );

endmodule

`default_nettype wire

/* dv/pattern_assert.sv */
`default_nettype none
`timescale 1ns/100ps

module pattern_assert (
    input logic                     clk,
    input logic                     i_reset,
    input logic [3:0]               i_digit,
    input logic                     i_shift_tick,
    input logic                     i_scan_tick,
    input logic                     i_mealy_hit,
    input detect_pkg::mealy_state_e i_mealy_state
);

    import detect_pkg::*;

    // The anodes are active low, and only one digit may be lit at a time.
    digit_one_hot: assert property (
        @(posedge clk) disable iff (i_reset) $onehot(~i_digit)
    ) else $error("o_digit is %b and does not select exactly one digit", i_digit);

    // Both tick generators wrap right after the strobe, so it cannot last two cycles.
    shift_tick_single: assert property (
        @(posedge clk) disable iff (i_reset) i_shift_tick |=> !i_shift_tick
    ) else $error("shift tick held high for more than one cycle");

    scan_tick_single: assert property (
        @(posedge clk) disable iff (i_reset) i_scan_tick |=> !i_scan_tick
    ) else $error("scan tick held high for more than one cycle");

    // A Mealy hit needs seen_10, so idle must keep it low.
    mealy_idle_quiet: assert property (
        @(posedge clk) disable iff (i_reset) (i_mealy_state == mealy_idle) |-> !i_mealy_hit
    ) else $error("Mealy hit raised while the Mealy FSM is idle");

endmodule

bind pattern_top pattern_assert u_pattern_assert (
    .clk           ( clk                          ),
    .i_reset       ( i_reset                      ),
    .i_digit       ( o_digit                      ),
    .i_shift_tick  ( shift_tick                   ),
    .i_scan_tick   ( scan_tick                    ),
    .i_mealy_hit   ( mealy_hit                    ),
    .i_mealy_state ( u_pattern_detect.mealy_state )
);

`default_nettype wire

/* dv/pattern_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module pattern_tb;

    // Short counters keep ticks, debounce and scan quick in simulation.
    localparam int debounce_depth   = 2;
    localparam int shift_tick_width = 5;
    localparam int scan_tick_width  = 2;
    localparam int tick_period      = 1 << shift_tick_width;
    localparam int reset_cycles     = 4;
    // A full scan of four digits takes 16 cycles, so 24 leaves some slack.
    localparam int scan_timeout     = 6 * (1 << scan_tick_width);
    // One cycle shorter than the debounce window, so it must be dropped.
    localparam int glitch_cycles    = (1 << debounce_depth) - 1;

    logic       clk = 1'b0;
    logic       i_reset;
    logic [3:0] key_sw;
    logic [3:0] o_led;
    logic [7:0] o_abcdefgh;
    logic [3:0] o_digit;

    // Reference model. Edges are counted from the edge that releases reset.
    int         edges;
    int         ticks;
    int         hits;
    logic [3:0] history;
    logic       key1_level;
    logic [7:0] lfsr_state;
    int         errors;
    int         timeouts;

    pattern_top # (
        .debounce_depth   ( debounce_depth   ),
        .shift_tick_width ( shift_tick_width ),
        .scan_tick_width  ( scan_tick_width  )
    ) DUT (
        .clk        ( clk        ),
        .i_reset    ( i_reset    ),
        .i_key_sw   ( key_sw     ),
        .o_led      ( o_led      ),
        .o_abcdefgh ( o_abcdefgh ),
        .o_digit    ( o_digit    )
    );

    // Period of 100 ns.
    always #50 clk = ~clk;

    // Galois LFSR for x^8 + x^6 + x^5 + x^4 + 1. The bit taken is bit 0.
    function automatic logic [7:0] lfsr_step(input logic [7:0] state);
        logic [7:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 8'hb8;
        end
        return next;
    endfunction

    // Reads an active-low abcdefg code back into a hex value, or -1 if no digit matches.
    function automatic int segments_to_hex(input logic [6:0] abcdefg_n);
        case (~abcdefg_n)
            7'b1111110: return 0;
            7'b0110000: return 1;
            7'b1101101: return 2;
            7'b1111001: return 3;
            7'b0110011: return 4;
            7'b1011011: return 5;
            7'b1011111: return 6;
            7'b1110000: return 7;
            7'b1111111: return 8;
            7'b1111011: return 9;
            7'b1110111: return 10;
            7'b0011111: return 11;
            7'b1001110: return 12;
            7'b0111101: return 13;
            7'b1001111: return 14;
            7'b1000111: return 15;
            default:    return -1;
        endcase
    endfunction

    // Every shift tick takes the held key 1 level into the model.
    // An overlapping 1-0-1 is counted as soon as its last bit is entered.
    function automatic void record_tick();
        ticks++;
        history = {history[2:0], key1_level};
        if (history[2:0] == 3'b101) begin
            hits++;
        end
    endfunction

    task automatic finish_run();
        $display("Closing counts: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        timeouts++;
        $display("Timeout at %0t: gave up waiting for %s", $time, what);
        finish_run();
    endtask

    task automatic compare(input string what, input int got, input int expected);
        if (got != expected) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, what, expected, got);
        end
    endtask

    // All edges go through here so that the model sees each tick edge.
    task automatic step_clock();
        @(posedge clk);
        edges++;
        if (edges % tick_period == 0) begin
            record_tick();
        end
    endtask

    // Phase 0 is a shift tick edge and phase 1 the edge right after it.
    task automatic wait_phase(input int phase);
        int n;
        n = 0;
        step_clock();
        while (edges % tick_period != phase && n < tick_period) begin
            step_clock();
            n++;
        end
        if (edges % tick_period != phase) begin
            abort_on_timeout("a shift tick phase");
        end
    endtask

    // Key 1 changes just after a tick, so it has settled long before the next one.
    task automatic shift_in(input logic data);
        wait_phase(1);
        key_sw[1] <= ~data;
        key1_level = data;
        wait_phase(0);
    endtask

    task automatic check_leds();
        logic [3:0] expected;
        expected = ~history;
        @(negedge clk);
        compare("LEDs", o_led, expected);
    endtask

    // Collects all four digits within one scan.
    // The first step lets the registered outputs pick up a count that changed on the tick.
    task automatic read_display(output logic [15:0] word, output logic [3:0] dots);
        logic [3:0] seen;
        logic [3:0] want;
        int         n;
        int         value;
        seen = '0;
        word = '0;
        dots = '0;
        n    = 0;
        step_clock();
        while (seen != 4'hf && n < scan_timeout) begin
            @(negedge clk);
            for (int k = 0; k < 4; k++) begin
                want = 4'b0001 << k;
                if (o_digit == ~want && !seen[k]) begin
                    value = segments_to_hex(o_abcdefgh[7:1]);
                    if (value < 0) begin
                        errors++;
                        $display("Digit %0d shows segment code %b, which is no hex digit",
                                 k, o_abcdefgh[7:1]);
                    end else begin
                        word[k*4 +: 4] = value[3:0];
                    end
                    dots[k] = ~o_abcdefgh[0];
                    seen[k] = 1'b1;
                end
            end
            step_clock();
            n++;
        end
        if (seen != 4'hf) begin
            abort_on_timeout("all four display digits");
        end
    endtask

    task automatic check_display(input logic [3:0] dots_expected);
        logic [15:0] word;
        logic [3:0]  dots;
        read_display(word, dots);
        compare("shift count digits", word[15:8], ticks % 256);
        compare("Moore hit digit", word[7:4], hits % 16);
        compare("Mealy hit digit", word[3:0], hits % 16);
        compare("dots", dots, dots_expected);
    endtask

    task automatic apply_reset();
        i_reset <= 1'b1;
        for (int n = 0; n < reset_cycles; n++) begin
            @(posedge clk);
        end
        i_reset <= 1'b0;
        edges = 0;
    endtask

    task automatic reset_state();
        check_leds();
        check_display(4'b0000);
    endtask

    // Key 1 held for three ticks, then released for three.
    task automatic shifting();
        for (int i = 0; i < 3; i++) begin
            shift_in(1'b1);
            check_leds();
        end
        for (int i = 0; i < 3; i++) begin
            shift_in(1'b0);
            check_leds();
        end
        check_display(4'b0000);
    endtask

    // Flips key 1 away from its held level for a few cycles from the given phase.
    task automatic pulse_key1(input int start);
        wait_phase(start);
        key_sw[1] <= key1_level;
        for (int n = 0; n < glitch_cycles; n++) begin
            step_clock();
        end
        key_sw[1] <= ~key1_level;
        wait_phase(0);
        check_leds();
    endtask

    // The early pulse would still be high at the tick through a debounce window that is too short.
    // The late pulse ends right before the tick, so a key without debounce would be sampled there.
    task automatic debounce_glitch();
        pulse_key1(tick_period - 8);
        pulse_key1(tick_period - 4);
        check_display(4'b0000);
    endtask

    // The stream holds three overlapping matches, and the zeros let both counts settle.
    task automatic pattern_counts();
        logic [7:0]  stream;
        logic [15:0] word;
        logic [3:0]  dots;
        int          hits_before;
        stream      = 8'b1010_1101;
        hits_before = hits;
        for (int i = 7; i >= 0; i--) begin
            shift_in(stream[i]);
        end
        for (int i = 0; i < 3; i++) begin
            shift_in(1'b0);
        end
        read_display(word, dots);
        compare("Moore hits after fixed stream", word[7:4], (hits_before + 3) % 16);
        compare("Mealy hits after fixed stream", word[3:0], (hits_before + 3) % 16);
        compare("shift count digits", word[15:8], ticks % 256);
    endtask

    task automatic random_stream();
        for (int i = 0; i < 40; i++) begin
            shift_in(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
        for (int i = 0; i < 3; i++) begin
            shift_in(1'b0);
        end
        check_display(4'b0000);
    endtask

    task automatic key_dots();
        wait_phase(1);
        key_sw[0] <= 1'b0;
        key_sw[3] <= 1'b0;
        wait_phase(0);
        check_display(4'b1001);
        wait_phase(1);
        key_sw[0] <= 1'b1;
        key_sw[3] <= 1'b1;
        wait_phase(0);
        check_display(4'b0000);
    endtask

    initial begin
        i_reset    = 1'b1;
        key_sw     = 4'hf;
        edges      = 0;
        ticks      = 0;
        hits       = 0;
        history    = '0;
        key1_level = 1'b0;
        lfsr_state = 8'd93;
        errors     = 0;
        timeouts   = 0;
        apply_reset();
        reset_state();
        shifting();
        debounce_glitch();
        pattern_counts();
        random_stream();
        key_dots();
        finish_run();
    end

endmodule

`default_nettype wire

/* sources.f */
hdl/board_pkg.sv
hdl/detect_pkg.sv
hdl/tick_gen.sv
hdl/key_debounce.sv
hdl/pattern_detect.sv
hdl/event_tally.sv
hdl/seven_segment.sv
hdl/pattern_top.sv
dv/pattern_assert.sv
dv/pattern_tb.sv

/* Bender.yml */
package:
  name: pattern_demo

sources:
  - hdl/board_pkg.sv
  - hdl/detect_pkg.sv
  - hdl/tick_gen.sv
  - hdl/key_debounce.sv
  - hdl/pattern_detect.sv
  - hdl/event_tally.sv
  - hdl/seven_segment.sv
  - hdl/pattern_top.sv
  - target: simulation
    files:
      - dv/pattern_assert.sv
      - dv/pattern_tb.sv
